/* hdl/vis_pkg.sv */
/* Vector issue stage shared definitions
   Opcodes carried to the execution stage and default sizes */

package vis_pkg;

    // ========================================
    // Opcodes
    // ========================================
    // Passed through untouched, decoded by the execution stage
    typedef enum logic [3:0] {
        VOP_ADD = 4'h0,
        VOP_SUB = 4'h1,
        VOP_AND = 4'h2,
        VOP_OR  = 4'h3,
        VOP_XOR = 4'h4,
        VOP_MUL = 4'h5
    } vis_op_e;

    // ========================================
    // Default sizes
    // ========================================
    localparam int DEF_VREGS    = 32;   // Architectural vector registers
    localparam int DEF_LANES    = 8;    // Must be a power of two
    localparam int DEF_DATA_W   = 32;   // Element width
    localparam int DEF_TICKET_W = 4;

endpackage

/* hdl/vreg_file.sv */
/* Vector register file
   Two combinational read ports and one lane-enabled write port */

`timescale 1ns/1ps

module vreg_file #(
    parameter int  VREGS  = vis_pkg::DEF_VREGS,
    parameter int  LANES  = vis_pkg::DEF_LANES,
    parameter int  DATA_W = vis_pkg::DEF_DATA_W,
    localparam int AW     = $clog2(VREGS)
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [AW-1:0]           rd_addr1_i,
    input  logic [AW-1:0]           rd_addr2_i,
    input  logic [LANES-1:0]        wr_en_i,      // One enable per lane
    input  logic [AW-1:0]           wr_addr_i,
    input  logic [LANES*DATA_W-1:0] wr_data_i,
    output logic [LANES*DATA_W-1:0] rd_data1_o,
    output logic [LANES*DATA_W-1:0] rd_data2_o
);

    // One row per register, lanes packed side by side
    logic [VREGS-1:0][LANES*DATA_W-1:0] regs;

    assign rd_data1_o = regs[rd_addr1_i];
    assign rd_data2_o = regs[rd_addr2_i];

    // ========================================
    // Lane-enabled write
    // ========================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            regs <= '0;
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (wr_en_i[k]) begin
                    regs[wr_addr_i][k*DATA_W +: DATA_W] <= wr_data_i[k*DATA_W +: DATA_W];
                end
            end
        end
    end

endmodule

/* hdl/uop_expander.sv */
/* Micro-op expander
   Walks an instruction in groups of LANES elements and drives the issue handshake */

`timescale 1ns/1ps

module uop_expander #(
    parameter int  VREGS = vis_pkg::DEF_VREGS,
    parameter int  LANES = vis_pkg::DEF_LANES,
    localparam int AW    = $clog2(VREGS),
    localparam int VLW   = $clog2(VREGS * LANES) + 1
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             instr_valid_i,
    input  logic [AW-1:0]    instr_src1_i,
    input  logic [AW-1:0]    instr_src2_i,
    input  logic [AW-1:0]    instr_dst_i,
    input  logic [VLW-1:0]   instr_vl_i,
    input  logic             issue_ready_i,
    input  logic             lanes_clear_i,
    output logic [AW-1:0]    src1_o,
    output logic [AW-1:0]    src2_o,
    output logic [AW-1:0]    dst_o,
    output logic [LANES-1:0] lane_therm_o,
    output logic             issue_fire_o,
    output logic             head_o,
    output logic             end_o,
    output logic [VLW-1:0]   remaining_vl_o,
    output logic             instr_ready_o
);

    localparam int LW = $clog2(LANES);

    logic [AW-1:0]  uop_cnt;        // Micro-ops already issued
    logic [VLW-1:0] done_elems;     // Elements covered before this micro-op
    logic [VLW-1:0] next_elems;     // Elements covered after it
    logic           last_uop;

    assign done_elems     = VLW'(uop_cnt) << LW;
    assign next_elems     = (VLW'(uop_cnt) + VLW'(1)) << LW;
    assign remaining_vl_o = instr_vl_i - done_elems;
    assign last_uop       = next_elems >= instr_vl_i;

    // Register numbers step by one per group
    assign src1_o = instr_src1_i + uop_cnt;
    assign src2_o = instr_src2_i + uop_cnt;
    assign dst_o  = instr_dst_i + uop_cnt;

    // Active lanes of the current group
    always_comb begin
        if (remaining_vl_o >= VLW'(LANES)) begin
            lane_therm_o = '1;
        end else begin
            lane_therm_o = ~({LANES{1'b1}} << remaining_vl_o);
        end
    end

    // ========================================
    // Issue handshake
    // ========================================
    assign issue_fire_o  = instr_valid_i & issue_ready_i & lanes_clear_i;
    assign head_o        = issue_fire_o & (uop_cnt == '0);
    assign end_o         = issue_fire_o & last_uop;
    assign instr_ready_o = end_o;   // Pop together with the last group

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            uop_cnt <= '0;
        end else if (instr_ready_o) begin
            uop_cnt <= '0;
        end else if (issue_fire_o) begin
            uop_cnt <= uop_cnt + AW'(1);
        end
    end

endmodule

/* hdl/operand_scoreboard.sv */
/* Operand scoreboard
   Per-lane pending tracking, writeback forwarding and the hazard check */

`timescale 1ns/1ps

module operand_scoreboard #(
    parameter int  VREGS    = vis_pkg::DEF_VREGS,
    parameter int  LANES    = vis_pkg::DEF_LANES,
    parameter int  DATA_W   = vis_pkg::DEF_DATA_W,
    parameter int  TICKET_W = vis_pkg::DEF_TICKET_W,
    localparam int AW       = $clog2(VREGS)
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [AW-1:0]           src1_i,
    input  logic [AW-1:0]           src2_i,
    input  logic [AW-1:0]           dst_i,
    input  logic [LANES-1:0]        lane_therm_i,
    input  logic                    issue_fire_i,
    input  logic [TICKET_W-1:0]     issue_ticket_i,
    input  logic [LANES*DATA_W-1:0] rd_data1_i,
    input  logic [LANES*DATA_W-1:0] rd_data2_i,
    input  logic [LANES-1:0]        wb_en_i,
    input  logic [AW-1:0]           wb_addr_i,
    input  logic [LANES*DATA_W-1:0] wb_data_i,
    input  logic [TICKET_W-1:0]     wb_ticket_i,
    input  logic                    instr_valid_i,
    output logic                    lanes_clear_o,
    output logic [LANES*DATA_W-1:0] data1_o,
    output logic [LANES*DATA_W-1:0] data2_o,
    output logic                    idle_o
);

    logic [VREGS-1:0][LANES-1:0]    pending;
    logic [VREGS-1:0][TICKET_W-1:0] pend_ticket;   // Owner of the pending lanes
    logic                           wb_match;
    logic [LANES-1:0]               hit1, hit2;
    logic [LANES-1:0]               src_ok;

    assign wb_match = (wb_ticket_i == pend_ticket[wb_addr_i]);

    // ========================================
    // Forwarding and hazard check
    // ========================================
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        assign hit1[k] = wb_en_i[k] & (wb_addr_i == src1_i) & (wb_ticket_i == pend_ticket[src1_i]);
        assign hit2[k] = wb_en_i[k] & (wb_addr_i == src2_i) & (wb_ticket_i == pend_ticket[src2_i]);

        assign data1_o[k*DATA_W +: DATA_W] = hit1[k] ? wb_data_i[k*DATA_W +: DATA_W]
                                                     : rd_data1_i[k*DATA_W +: DATA_W];
        assign data2_o[k*DATA_W +: DATA_W] = hit2[k] ? wb_data_i[k*DATA_W +: DATA_W]
                                                     : rd_data2_i[k*DATA_W +: DATA_W];

        assign src_ok[k] = (~pending[src1_i][k] | hit1[k]) & (~pending[src2_i][k] | hit2[k]);
    end

    assign lanes_clear_o = &(src_ok | ~lane_therm_i);   // Inactive lanes never block
    assign idle_o        = ~instr_valid_i & ~|pending;

    // Issue wins over a writeback on the same register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending     <= '0;
            pend_ticket <= '0;
        end else begin
            for (int r = 0; r < VREGS; r++) begin
                if (issue_fire_i && dst_i == AW'(r)) begin
                    pending[r]     <= lane_therm_i;
                    pend_ticket[r] <= issue_ticket_i;
                end else if (wb_match && wb_addr_i == AW'(r)) begin
                    pending[r] <= pending[r] & ~wb_en_i;
                end
            end
        end
    end

endmodule

/* hdl/vis_top.sv */
/* Vector issue stage top level
   Joins the micro-op expander, the pending scoreboard and the register file */

`timescale 1ns/1ps

module vis_top #(
    parameter int  VREGS    = vis_pkg::DEF_VREGS,
    parameter int  LANES    = vis_pkg::DEF_LANES,
    parameter int  DATA_W   = vis_pkg::DEF_DATA_W,
    parameter int  TICKET_W = vis_pkg::DEF_TICKET_W,
    localparam int AW       = $clog2(VREGS),
    localparam int VLW      = $clog2(VREGS * LANES) + 1
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // Instruction in
    input  logic                      instr_valid_i,
    input  vis_pkg::vis_op_e          instr_op_i,
    input  logic [AW-1:0]             instr_src1_i,
    input  logic [AW-1:0]             instr_src2_i,
    input  logic [AW-1:0]             instr_dst_i,
    input  logic [VLW-1:0]            instr_vl_i,
    input  logic [TICKET_W-1:0]       instr_ticket_i,
    output logic                      instr_ready_o,
    // Micro-op out
    output logic                      issue_valid_o,
    output logic [LANES-1:0]          issue_lane_valid_o,
    output logic [LANES*DATA_W-1:0]   issue_data1_o,
    output logic [LANES*DATA_W-1:0]   issue_data2_o,
    output vis_pkg::vis_op_e          issue_op_o,
    output logic [AW-1:0]             issue_dst_o,
    output logic [TICKET_W-1:0]       issue_ticket_o,
    output logic                      issue_head_o,
    output logic                      issue_end_o,
    output logic [VLW-1:0]            issue_vl_o,
    input  logic                      issue_ready_i,
    // Writeback
    input  logic [LANES-1:0]          wb_en_i,
    input  logic [AW-1:0]             wb_addr_i,
    input  logic [LANES*DATA_W-1:0]   wb_data_i,
    input  logic [TICKET_W-1:0]       wb_ticket_i,
    output logic                      idle_o
);

    logic [AW-1:0]           src1, src2, dst;
    logic [LANES-1:0]        lane_therm;
    logic                    issue_fire;
    logic                    lanes_clear;
    logic [LANES*DATA_W-1:0] rd_data1, rd_data2;

    // Instruction fields that ride along with every micro-op
    assign issue_valid_o      = issue_fire;
    assign issue_lane_valid_o = lane_therm;
    assign issue_op_o         = instr_op_i;
    assign issue_dst_o        = dst;
    assign issue_ticket_o     = instr_ticket_i;

    uop_expander #(.VREGS(VREGS), .LANES(LANES)) u_expander (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .instr_valid_i(instr_valid_i), .instr_src1_i(instr_src1_i),
        .instr_src2_i(instr_src2_i), .instr_dst_i(instr_dst_i),
        .instr_vl_i(instr_vl_i), .issue_ready_i(issue_ready_i),
        .lanes_clear_i(lanes_clear),
        .src1_o(src1), .src2_o(src2), .dst_o(dst), .lane_therm_o(lane_therm),
        .issue_fire_o(issue_fire), .head_o(issue_head_o), .end_o(issue_end_o),
        .remaining_vl_o(issue_vl_o), .instr_ready_o(instr_ready_o)
    );

    operand_scoreboard #(
        .VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W), .TICKET_W(TICKET_W)
    ) u_scoreboard (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .src1_i(src1), .src2_i(src2), .dst_i(dst), .lane_therm_i(lane_therm),
        .issue_fire_i(issue_fire), .issue_ticket_i(instr_ticket_i),
        .rd_data1_i(rd_data1), .rd_data2_i(rd_data2),
        .wb_en_i(wb_en_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
        .wb_ticket_i(wb_ticket_i), .instr_valid_i(instr_valid_i),
        .lanes_clear_o(lanes_clear), .data1_o(issue_data1_o),
        .data2_o(issue_data2_o), .idle_o(idle_o)
    );

    vreg_file #(.VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W)) u_vrf (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .rd_addr1_i(src1), .rd_addr2_i(src2),
        .wr_en_i(wb_en_i), .wr_addr_i(wb_addr_i), .wr_data_i(wb_data_i),
        .rd_data1_o(rd_data1), .rd_data2_o(rd_data2)
    );

endmodule

/* test/vis_asserts.sv */
/* Issue stage assertions
   Handshake and lane-shape properties bound to the top level */

`timescale 1ns/1ps

module vis_asserts #(
    parameter int  VREGS = vis_pkg::DEF_VREGS,
    parameter int  LANES = vis_pkg::DEF_LANES,
    localparam int VLW   = $clog2(VREGS * LANES) + 1
) (
    input logic             clk_i,
    input logic             rstn_i,
    input logic             instr_valid_i,
    input logic             issue_valid_i,
    input logic             issue_ready_i,
    input logic             issue_end_i,
    input logic             instr_ready_i,
    input logic [LANES-1:0] lane_valid_i,
    input logic [VLW-1:0]   issue_vl_i
);

    // Active lanes form a nonzero run starting at lane 0
    a_lane_shape: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_valid_i |-> (lane_valid_i != '0) &&
                          ((lane_valid_i & (lane_valid_i + LANES'(1))) == '0))
        else $error("issue_lane_valid_o is not a nonzero thermometer");

    // The last group covers what is left of vl
    a_ready_at_end: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_ready_i |-> issue_end_i && (issue_vl_i <= VLW'(LANES)))
        else $error("instr_ready_o raised without a final group");

    a_no_issue_stalled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !issue_ready_i |-> !issue_valid_i)
        else $error("issue_valid_o raised while issue_ready_i is low");

    a_stall_holds_count: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_i && !issue_ready_i |=> issue_vl_i == $past(issue_vl_i))
        else $error("micro-op counter moved during a stall");

endmodule

bind vis_top vis_asserts #(.VREGS(VREGS), .LANES(LANES)) u_asserts (
    .clk_i(clk_i), .rstn_i(rstn_i), .instr_valid_i(instr_valid_i),
    .issue_valid_i(issue_valid_o), .issue_ready_i(issue_ready_i),
    .issue_end_i(issue_end_o), .instr_ready_i(instr_ready_o),
    .lane_valid_i(issue_lane_valid_o), .issue_vl_i(issue_vl_o)
);

/* test/vis_tb.sv */
/* Vector issue stage testbench
   Directed tests, acting as execution stage and writeback source */

`timescale 1ns/1ps

module vis_tb;

    import vis_pkg::*;

    localparam int VREGS    = DEF_VREGS;
    localparam int LANES    = DEF_LANES;
    localparam int DATA_W   = DEF_DATA_W;
    localparam int TICKET_W = DEF_TICKET_W;
    localparam int AW       = $clog2(VREGS);
    localparam int VLW      = $clog2(VREGS * LANES) + 1;
    localparam int DW       = LANES * DATA_W;
    localparam int TIMEOUT  = 20;   // Cycles per wait

    logic                clk, rstn;
    logic                instr_valid, instr_ready, issue_ready, idle;
    vis_op_e             instr_op, issue_op;
    logic [AW-1:0]       instr_src1, instr_src2, instr_dst, issue_dst, wb_addr;
    logic [VLW-1:0]      instr_vl, issue_vl;
    logic [TICKET_W-1:0] instr_ticket, issue_ticket, wb_ticket;
    logic                issue_valid, issue_head, issue_end;
    logic [LANES-1:0]    issue_lanes, wb_en;
    logic [DW-1:0]       issue_data1, issue_data2, wb_data;
    logic [DW-1:0]       model [VREGS];   // Expected register contents
    logic [31:0]         lfsr;

    vis_top #(
        .VREGS(VREGS), .LANES(LANES), .DATA_W(DATA_W), .TICKET_W(TICKET_W)
    ) dut_i (
        .clk_i(clk), .rstn_i(rstn),
        .instr_valid_i(instr_valid), .instr_op_i(instr_op), .instr_src1_i(instr_src1),
        .instr_src2_i(instr_src2), .instr_dst_i(instr_dst), .instr_vl_i(instr_vl),
        .instr_ticket_i(instr_ticket), .instr_ready_o(instr_ready),
        .issue_valid_o(issue_valid), .issue_lane_valid_o(issue_lanes),
        .issue_data1_o(issue_data1), .issue_data2_o(issue_data2), .issue_op_o(issue_op),
        .issue_dst_o(issue_dst), .issue_ticket_o(issue_ticket), .issue_head_o(issue_head),
        .issue_end_o(issue_end), .issue_vl_o(issue_vl), .issue_ready_i(issue_ready),
        .wb_en_i(wb_en), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
        .wb_ticket_i(wb_ticket), .idle_o(idle)
    );

    always #5 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic rand_vec(output logic [DW-1:0] v);
        for (int b = 0; b < DW; b++) begin
            lfsr = lfsr_step(lfsr);
            v[b] = lfsr[0];    // One step per bit
        end
    endtask

    task automatic check(input string name, input logic [DW-1:0] actual,
                         input logic [DW-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h",
                     $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Drives a writeback with random data and mirrors the enabled lanes in the model
    task automatic drive_wb(input logic [AW-1:0] addr, input logic [LANES-1:0] en,
                            input logic [TICKET_W-1:0] ticket);
        logic [DW-1:0] data;
        rand_vec(data);
        wb_en     = en;
        wb_addr   = addr;
        wb_data   = data;
        wb_ticket = ticket;
        for (int k = 0; k < LANES; k++) begin
            if (en[k]) begin
                model[addr][k*DATA_W +: DATA_W] = data[k*DATA_W +: DATA_W];
            end
        end
    endtask

    task automatic write_back(input logic [AW-1:0] addr, input logic [LANES-1:0] en,
                              input logic [TICKET_W-1:0] ticket);
        drive_wb(addr, en, ticket);
        @(negedge clk);
        wb_en = '0;
    endtask

    task automatic send_instr(input logic [AW-1:0] s1, input logic [AW-1:0] s2,
                              input logic [AW-1:0] dst, input logic [VLW-1:0] vl,
                              input logic [TICKET_W-1:0] ticket, input vis_op_e op);
        instr_valid  = 1'b1;
        instr_src1   = s1;
        instr_src2   = s2;
        instr_dst    = dst;
        instr_vl     = vl;
        instr_ticket = ticket;
        instr_op     = op;
    endtask

    // Waits for the next micro-op, checks it, returns after the consuming edge
    task automatic expect_uop(input logic [AW-1:0] dst, input logic [AW-1:0] s1,
                              input logic [AW-1:0] s2, input logic [VLW-1:0] vl,
                              input logic head, input logic last);
        logic [LANES-1:0] lanes;
        int               n;
        lanes = (vl >= VLW'(LANES)) ? '1 : LANES'((1 << vl) - 1);
        n = 0;
        #1;
        while (!issue_valid) begin
            if (n == TIMEOUT) begin
                $display("Timeout: micro-op for register %0d never issued", dst);
                $display("test failed");
                $fatal(1, "issue timeout");
            end
            @(negedge clk);
            #1;
            n++;
        end
        check("issue_dst_o", DW'(issue_dst), DW'(dst));
        check("issue_data1_o", issue_data1, model[s1]);
        check("issue_data2_o", issue_data2, model[s2]);
        check("issue_lane_valid_o", DW'(issue_lanes), DW'(lanes));
        check("issue_vl_o", DW'(issue_vl), DW'(vl));
        check("issue_head_o", DW'(issue_head), DW'(head));
        check("issue_end_o", DW'(issue_end), DW'(last));
        check("instr_ready_o", DW'(instr_ready), DW'(last));
        check("issue_ticket_o", DW'(issue_ticket), DW'(instr_ticket));
        check("issue_op_o", DW'(issue_op), DW'(instr_op));
        @(negedge clk);
    endtask

    task automatic expect_idle();
        #1;
        check("idle_o", DW'(idle), DW'(1));
        @(negedge clk);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_single();
        write_back(2, '1, 0);
        write_back(3, '1, 0);
        issue_ready = 1'b1;
        send_instr(2, 3, 4, 5, 1, VOP_ADD);
        expect_uop(4, 2, 3, 5, 1'b1, 1'b1);
        instr_valid = 1'b0;
        write_back(4, 8'h1F, 1);
        expect_idle();
    endtask

    task automatic test_expand();
        for (int r = 10; r < 16; r++) begin
            write_back(AW'(r), '1, 0);
        end
        send_instr(10, 13, 20, 20, 2, VOP_MUL);
        expect_uop(20, 10, 13, 20, 1'b1, 1'b0);
        expect_uop(21, 11, 14, 12, 1'b0, 1'b0);
        expect_uop(22, 12, 15, 4, 1'b0, 1'b1);
        instr_valid = 1'b0;
        #1;
        check("idle_o", DW'(idle), DW'(0));   // Destinations still pending
        @(negedge clk);
        write_back(20, '1, 2);
        write_back(21, '1, 2);
        write_back(22, 8'h0F, 2);
        expect_idle();
    endtask

    task automatic test_backpressure();
        for (int r = 16; r < 20; r++) begin
            write_back(AW'(r), '1, 0);
        end
        send_instr(16, 17, 24, 24, 3, VOP_SUB);
        expect_uop(24, 16, 17, 24, 1'b1, 1'b0);
        issue_ready = 1'b0;
        repeat (4) begin
            #1;
            check("issue_valid_o", DW'(issue_valid), DW'(0));
            check("instr_ready_o", DW'(instr_ready), DW'(0));
            check("issue_vl_o", DW'(issue_vl), DW'(16));   // Counter held
            @(negedge clk);
        end
        issue_ready = 1'b1;
        expect_uop(25, 17, 18, 16, 1'b0, 1'b0);
        expect_uop(26, 18, 19, 8, 1'b0, 1'b1);
        instr_valid = 1'b0;
        write_back(24, '1, 3);
        write_back(25, '1, 3);
        write_back(26, '1, 3);
        expect_idle();
    endtask

    task automatic test_hazard();
        send_instr(2, 3, 9, 8, 5, VOP_XOR);   // A writes register 9
        expect_uop(9, 2, 3, 8, 1'b1, 1'b1);
        send_instr(9, 3, 11, 8, 6, VOP_OR);   // B reads it
        #1;
        check("issue_valid_o", DW'(issue_valid), DW'(0));
        check("idle_o", DW'(idle), DW'(0));
        @(negedge clk);
        drive_wb(9, '1, 7);                   // Foreign ticket
        #1;
        check("issue_valid_o", DW'(issue_valid), DW'(0));
        @(negedge clk);
        wb_en = '0;
        #1;
        check("issue_valid_o", DW'(issue_valid), DW'(0));
        check("issue_data1_o", issue_data1, model[9]);   // Data landed anyway
        @(negedge clk);
        drive_wb(9, '1, 5);                   // Releases B through forwarding
        #1;
        check("issue_valid_o", DW'(issue_valid), DW'(1));   // Same cycle as the writeback
        expect_uop(11, 9, 3, 8, 1'b1, 1'b1);
        wb_en       = '0;
        instr_valid = 1'b0;
        write_back(11, '1, 6);
        expect_idle();
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        issue_ready  = 1'b0;
        wb_en        = '0;
        wb_addr      = '0;
        wb_data      = '0;
        wb_ticket    = '0;
        send_instr(0, 0, 0, 1, 0, VOP_ADD);
        instr_valid  = 1'b0;
        lfsr         = 32'd84;
        for (int r = 0; r < VREGS; r++) begin
            model[r] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        check("idle_o", DW'(idle), DW'(1));
        check("issue_valid_o", DW'(issue_valid), DW'(0));
        check("instr_ready_o", DW'(instr_ready), DW'(0));
        @(negedge clk);
        test_single();
        test_expand();
        test_backpressure();
        test_hazard();
        $display("test passed");
        $finish;
    end

endmodule

/* vis.f */
hdl/vis_pkg.sv
hdl/vreg_file.sv
hdl/uop_expander.sv
hdl/operand_scoreboard.sv
hdl/vis_top.sv
test/vis_asserts.sv
test/vis_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= vis_tb
FILELIST  ?= vis.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the simulation with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
